// ==== design/rng_defines.svh ====
// Random byte source parameters
`ifndef RNG_DEFINES_SVH
`define RNG_DEFINES_SVH

// Bus and datapath widths
`define RNG_ADDR_WIDTH  4
`define RNG_DATA_WIDTH  8
`define RNG_FIFO_DEPTH  8

// LFSR seeds
`define RNG_SEED_A      8'hFE
`define RNG_SEED_B      8'hBD
`define RNG_SEED_C      8'h73

// Register offsets
`define RNG_REG_RND     4'h0
`define RNG_REG_EN      4'h4
`define RNG_REG_RESEED  4'h8
`define RNG_REG_STATUS  4'hC

// AXI response codes
`define RNG_RESP_OKAY   2'd0
`define RNG_RESP_SLVERR 2'd2

`endif

// ==== design/rng_pkg.sv ====
// Random byte source types
`default_nettype none

`include "rng_defines.svh"

package rng_pkg;

    // Datapath and bus vectors
    typedef logic [`RNG_DATA_WIDTH-1:0] rnd_byte_t;
    typedef logic [`RNG_ADDR_WIDTH-1:0] axil_addr_t;
    typedef logic [1:0]                 axil_resp_t;

    // Holds 0 up to the full depth
    typedef logic [$clog2(`RNG_FIFO_DEPTH+1)-1:0] fifo_count_t;

    // Producer handshake
    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_REQ,
        GEN_RELEASE
    } gen_state_e;

    typedef enum logic {RD_ADDR, RD_DATA} rd_state_e;
    typedef enum logic {WR_ADDR, WR_RESP} wr_state_e;

endpackage

`default_nettype wire

// ==== design/triple_lfsr_gen.sv ====
// Triple LFSR byte producer
`timescale 1ns/1ps
`default_nettype none

`include "rng_defines.svh"

module triple_lfsr_gen (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire logic              en,
    input  wire logic              reseed,
    output logic                   link_req,
    output rng_pkg::rnd_byte_t     link_data,
    input  wire logic              link_ack
);

    rng_pkg::rnd_byte_t lfsr_a;
    rng_pkg::rnd_byte_t lfsr_b;
    rng_pkg::rnd_byte_t lfsr_c;
    rng_pkg::gen_state_e state;

    // Fibonacci step, feedback from the MSB and one tap
    function automatic rng_pkg::rnd_byte_t lfsr_step(
        input rng_pkg::rnd_byte_t s,
        input int unsigned        tap
    );
        return {s[`RNG_DATA_WIDTH-2:0], s[`RNG_DATA_WIDTH-1] ^ s[tap]};
    endfunction

    // Combined byte of the current state, wraps modulo 256
    assign link_data = (lfsr_a ^ lfsr_b) + ~lfsr_c;

    assign link_req = (state == rng_pkg::GEN_REQ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= rng_pkg::GEN_IDLE;
            lfsr_a <= `RNG_SEED_A;
            lfsr_b <= `RNG_SEED_B;
            lfsr_c <= `RNG_SEED_C;
        end else if (reseed) begin
            // Restart the sequence and abandon any offer
            state  <= rng_pkg::GEN_IDLE;
            lfsr_a <= `RNG_SEED_A;
            lfsr_b <= `RNG_SEED_B;
            lfsr_c <= `RNG_SEED_C;
        end else begin
            case (state)
                rng_pkg::GEN_IDLE: begin
                    // Ack may still be high after a reseed
                    if (en && !link_ack) begin
                        state <= rng_pkg::GEN_REQ;
                    end
                end
                rng_pkg::GEN_REQ: begin
                    if (link_ack) begin
                        state  <= rng_pkg::GEN_RELEASE;
                        lfsr_a <= lfsr_step(lfsr_a, 3);
                        lfsr_b <= lfsr_step(lfsr_b, 2);
                        lfsr_c <= lfsr_step(lfsr_c, 1);
                    end
                end
                rng_pkg::GEN_RELEASE: begin
                    if (!link_ack) begin
                        state <= rng_pkg::GEN_IDLE;
                    end
                end
                default: begin
                    state <= rng_pkg::GEN_IDLE;
                end
            endcase
        end
    end

    // Offered byte must not change under the FIFO
    assert property (@(posedge clk) disable iff (!rst_n)
        link_req ##1 link_req |-> $stable(link_data))
        else $error("link_data changed while link_req was high");

endmodule

`default_nettype wire

// ==== design/rnd_fifo.sv ====
// Four-phase receiver and byte FIFO
`timescale 1ns/1ps
`default_nettype none

`include "rng_defines.svh"

module rnd_fifo #(
    parameter int DEPTH = `RNG_FIFO_DEPTH
) (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  link_req,
    input  wire rng_pkg::rnd_byte_t    link_data,
    output logic                       link_ack,
    input  wire logic                  flush,
    input  wire logic                  pop,
    output rng_pkg::rnd_byte_t         fifo_data,
    output rng_pkg::fifo_count_t       fifo_count
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    rng_pkg::rnd_byte_t mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic               room;
    logic               push;
    logic               do_pop;

    assign room   = (fifo_count < rng_pkg::fifo_count_t'(DEPTH));
    // New byte accepted only on the rising edge of ack
    assign push   = !flush && link_req && !link_ack && room;
    assign do_pop = !flush && pop;

    assign fifo_data = mem[rd_ptr];

    // Receiver side of the handshake
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            link_ack <= 1'b0;
        end else if (flush) begin
            link_ack <= 1'b0;
        end else if (push) begin
            link_ack <= 1'b1;
        end else if (link_ack && !link_req) begin
            link_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else if (flush) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, do_pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= link_data;
        end
    end

    // Slave must check the count before popping
    assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> (fifo_count != '0))
        else $error("pop issued on empty FIFO");

    assert property (@(posedge clk) disable iff (!rst_n)
        fifo_count <= rng_pkg::fifo_count_t'(DEPTH))
        else $error("FIFO count above depth");

endmodule

`default_nettype wire

// ==== design/axil_rng_regs.sv ====
// AXI4-Lite register slave
`timescale 1ns/1ps
`default_nettype none

`include "rng_defines.svh"

module axil_rng_regs (
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    // Write address and data
    input  wire rng_pkg::axil_addr_t   s_axi_awaddr,
    input  wire logic                  s_axi_awvalid,
    output logic                       s_axi_awready,
    input  wire rng_pkg::rnd_byte_t    s_axi_wdata,
    input  wire logic [0:0]            s_axi_wstrb,
    input  wire logic                  s_axi_wvalid,
    output logic                       s_axi_wready,

    // Write response
    output rng_pkg::axil_resp_t        s_axi_bresp,
    output logic                       s_axi_bvalid,
    input  wire logic                  s_axi_bready,

    // Read address and data
    input  wire rng_pkg::axil_addr_t   s_axi_araddr,
    input  wire logic                  s_axi_arvalid,
    output logic                       s_axi_arready,
    output rng_pkg::rnd_byte_t         s_axi_rdata,
    output rng_pkg::axil_resp_t        s_axi_rresp,
    output logic                       s_axi_rvalid,
    input  wire logic                  s_axi_rready,

    // FIFO and producer control
    input  wire rng_pkg::rnd_byte_t    fifo_data,
    input  wire rng_pkg::fifo_count_t  fifo_count,
    output logic                       pop,
    output logic                       gen_en,
    output logic                       reseed
);

    rng_pkg::wr_state_e  wr_state;
    rng_pkg::rd_state_e  rd_state;
    rng_pkg::axil_addr_t awaddr_q;
    rng_pkg::axil_addr_t araddr_q;
    rng_pkg::rnd_byte_t  wdata_q;

    // Single strobe bit, byte always written whole
    assign s_axi_bvalid = (wr_state == rng_pkg::WR_RESP);
    assign s_axi_rvalid = (rd_state == rng_pkg::RD_DATA);

    // Pop coincides with the edge that raises rvalid
    assign pop = (rd_state == rng_pkg::RD_ADDR) && !s_axi_arready
              && (araddr_q == `RNG_REG_RND) && (fifo_count != '0);

    // Captured address and data
    always_ff @(posedge clk) begin
        if (s_axi_awvalid && s_axi_awready) begin
            awaddr_q <= s_axi_awaddr;
        end
        if (s_axi_wvalid && s_axi_wready) begin
            wdata_q <= s_axi_wdata;
        end
        if (s_axi_arvalid && s_axi_arready) begin
            araddr_q <= s_axi_araddr;
        end
    end

    // Write channel and control registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state      <= rng_pkg::WR_ADDR;
            s_axi_awready <= 1'b1;
            s_axi_wready  <= 1'b1;
            s_axi_bresp   <= `RNG_RESP_OKAY;
            gen_en        <= 1'b0;
            reseed        <= 1'b0;
        end else begin
            reseed <= 1'b0;
            case (wr_state)
                rng_pkg::WR_ADDR: begin
                    if (s_axi_awvalid && s_axi_awready) begin
                        s_axi_awready <= 1'b0;
                    end
                    if (s_axi_wvalid && s_axi_wready) begin
                        s_axi_wready <= 1'b0;
                    end
                    // Both halves in, apply and respond
                    if (!s_axi_awready && !s_axi_wready) begin
                        wr_state <= rng_pkg::WR_RESP;
                        case (awaddr_q)
                            `RNG_REG_EN: begin
                                gen_en      <= wdata_q[0];
                                s_axi_bresp <= `RNG_RESP_OKAY;
                            end
                            `RNG_REG_RESEED: begin
                                reseed      <= wdata_q[0];
                                s_axi_bresp <= `RNG_RESP_OKAY;
                            end
                            default: begin
                                s_axi_bresp <= `RNG_RESP_SLVERR;
                            end
                        endcase
                    end
                end
                rng_pkg::WR_RESP: begin
                    if (s_axi_bready) begin
                        wr_state      <= rng_pkg::WR_ADDR;
                        s_axi_awready <= 1'b1;
                        s_axi_wready  <= 1'b1;
                    end
                end
                default: begin
                    wr_state <= rng_pkg::WR_ADDR;
                end
            endcase
        end
    end

    // Read channel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state      <= rng_pkg::RD_ADDR;
            s_axi_arready <= 1'b1;
            s_axi_rdata   <= '0;
            s_axi_rresp   <= `RNG_RESP_OKAY;
        end else begin
            case (rd_state)
                rng_pkg::RD_ADDR: begin
                    if (s_axi_arvalid && s_axi_arready) begin
                        s_axi_arready <= 1'b0;
                    end else if (!s_axi_arready) begin
                        rd_state    <= rng_pkg::RD_DATA;
                        s_axi_rdata <= '0;
                        s_axi_rresp <= `RNG_RESP_OKAY;
                        case (araddr_q)
                            `RNG_REG_RND: begin
                                // Empty FIFO is an error, not a zero byte
                                if (fifo_count != '0) begin
                                    s_axi_rdata <= fifo_data;
                                end else begin
                                    s_axi_rresp <= `RNG_RESP_SLVERR;
                                end
                            end
                            `RNG_REG_EN:     s_axi_rdata <= rng_pkg::rnd_byte_t'(gen_en);
                            `RNG_REG_RESEED: s_axi_rdata <= '0;
                            `RNG_REG_STATUS: s_axi_rdata <= rng_pkg::rnd_byte_t'(fifo_count);
                            default:         s_axi_rresp <= `RNG_RESP_SLVERR;
                        endcase
                    end
                end
                rng_pkg::RD_DATA: begin
                    if (s_axi_rready) begin
                        rd_state      <= rng_pkg::RD_ADDR;
                        s_axi_arready <= 1'b1;
                    end
                end
                default: begin
                    rd_state <= rng_pkg::RD_ADDR;
                end
            endcase
        end
    end

    // No new write address while a response is pending
    assert property (@(posedge clk) disable iff (!rst_n)
        !(s_axi_bvalid && s_axi_awready))
        else $error("bvalid high with awready high");

endmodule

`default_nettype wire

// ==== design/lfsr_rng_axil.sv ====
// Memory-mapped random byte source
`timescale 1ns/1ps
`default_nettype none

module lfsr_rng_axil (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire rng_pkg::axil_addr_t   s_axi_awaddr,
    input  wire logic                  s_axi_awvalid,
    output logic                       s_axi_awready,
    input  wire rng_pkg::rnd_byte_t    s_axi_wdata,
    input  wire logic [0:0]            s_axi_wstrb,
    input  wire logic                  s_axi_wvalid,
    output logic                       s_axi_wready,
    output rng_pkg::axil_resp_t        s_axi_bresp,
    output logic                       s_axi_bvalid,
    input  wire logic                  s_axi_bready,
    input  wire rng_pkg::axil_addr_t   s_axi_araddr,
    input  wire logic                  s_axi_arvalid,
    output logic                       s_axi_arready,
    output rng_pkg::rnd_byte_t         s_axi_rdata,
    output rng_pkg::axil_resp_t        s_axi_rresp,
    output logic                       s_axi_rvalid,
    input  wire logic                  s_axi_rready
);

    // Producer to FIFO link
    logic                 link_req;
    logic                 link_ack;
    rng_pkg::rnd_byte_t   link_data;

    // FIFO to slave
    rng_pkg::rnd_byte_t   fifo_data;
    rng_pkg::fifo_count_t fifo_count;
    logic                 pop;

    // Slave controls
    logic                 gen_en;
    logic                 reseed;

    triple_lfsr_gen triple_lfsr_gen_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .en        (gen_en),
        .reseed    (reseed),
        .link_req  (link_req),
        .link_data (link_data),
        .link_ack  (link_ack)
    );

    rnd_fifo rnd_fifo_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .link_req   (link_req),
        .link_data  (link_data),
        .link_ack   (link_ack),
        .flush      (reseed),
        .pop        (pop),
        .fifo_data  (fifo_data),
        .fifo_count (fifo_count)
    );

    axil_rng_regs axil_rng_regs_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .fifo_data     (fifo_data),
        .fifo_count    (fifo_count),
        .pop           (pop),
        .gen_en        (gen_en),
        .reseed        (reseed)
    );

endmodule

`default_nettype wire

// ==== bench/tb_lfsr_rng_axil.sv ====
// Random byte source testbench
`timescale 1ns/1ps
`default_nettype none

module tb_lfsr_rng_axil;

    logic                 clk;
    logic                 rst_n;
    rng_pkg::axil_addr_t  s_axi_awaddr;
    logic                 s_axi_awvalid;
    logic                 s_axi_awready;
    rng_pkg::rnd_byte_t   s_axi_wdata;
    logic [0:0]           s_axi_wstrb;
    logic                 s_axi_wvalid;
    logic                 s_axi_wready;
    rng_pkg::axil_resp_t  s_axi_bresp;
    logic                 s_axi_bvalid;
    logic                 s_axi_bready;
    rng_pkg::axil_addr_t  s_axi_araddr;
    logic                 s_axi_arvalid;
    logic                 s_axi_arready;
    rng_pkg::rnd_byte_t   s_axi_rdata;
    rng_pkg::axil_resp_t  s_axi_rresp;
    logic                 s_axi_rvalid;
    logic                 s_axi_rready;

    // Vector table
    string                vec_name[$];
    string                vec_op[$];
    rng_pkg::axil_addr_t  vec_addr[$];
    rng_pkg::rnd_byte_t   vec_wdata[$];
    rng_pkg::rnd_byte_t   vec_data[$];
    rng_pkg::axil_resp_t  vec_resp[$];

    logic [15:0]          lfsr_state;
    int                   cycle_count;
    int                   cycle_limit;

    lfsr_rng_axil lfsr_rng_axil_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_byte(input string name, input rng_pkg::rnd_byte_t expected,
                              input rng_pkg::rnd_byte_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: expected %02h, actual %02h", name, expected, actual));
        end
    endtask

    task automatic check_resp(input string name, input rng_pkg::axil_resp_t expected,
                              input rng_pkg::axil_resp_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL %s: expected resp %0d, actual resp %0d",
                                name, expected, actual));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Two fresh bits give a wait of 0 to 3 cycles
    task automatic draw_wait(output int cycles);
        cycles = 0;
        repeat (2) begin
            lfsr_state = lfsr_next(lfsr_state);
            cycles = (cycles << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic axil_write(input rng_pkg::axil_addr_t addr, input rng_pkg::rnd_byte_t data,
                              output rng_pkg::axil_resp_t resp);
        int  delay;
        bit  aw_done;
        bit  w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge clk);
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wstrb   <= 1'b1;
        s_axi_wvalid  <= 1'b1;
        do begin
            @(posedge clk);
            if (s_axi_awvalid && s_axi_awready) begin
                aw_done = 1'b1;
                s_axi_awvalid <= 1'b0;
            end
            if (s_axi_wvalid && s_axi_wready) begin
                w_done = 1'b1;
                s_axi_wvalid <= 1'b0;
            end
        end while (!(aw_done && w_done));
        draw_wait(delay);
        repeat (delay) @(posedge clk);
        s_axi_bready <= 1'b1;
        do begin
            @(posedge clk);
        end while (!s_axi_bvalid);
        resp = s_axi_bresp;
        s_axi_bready <= 1'b0;
    endtask

    task automatic axil_read(input rng_pkg::axil_addr_t addr, output rng_pkg::rnd_byte_t data,
                             output rng_pkg::axil_resp_t resp);
        int delay;
        @(posedge clk);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!s_axi_arready);
        s_axi_arvalid <= 1'b0;
        draw_wait(delay);
        repeat (delay) @(posedge clk);
        s_axi_rready <= 1'b1;
        // Data and response hold until this handshake
        do begin
            @(posedge clk);
        end while (!s_axi_rvalid);
        data = s_axi_rdata;
        resp = s_axi_rresp;
        s_axi_rready <= 1'b0;
    endtask

    task automatic load_vectors();
        int    fd;
        int    fields;
        int    addr;
        int    wdata;
        int    data;
        int    resp;
        string line;
        string name;
        string op;
        fd = $fopen("bench/rng_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the vector file bench/rng_vectors.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %s %h %h %h %h",
                                     name, op, addr, wdata, data, resp);
                    if (fields != 6) begin
                        abort_run($sformatf("Vector line could not be parsed: %s", line));
                    end else begin
                        vec_name.push_back(name);
                        vec_op.push_back(op);
                        vec_addr.push_back(rng_pkg::axil_addr_t'(addr));
                        vec_wdata.push_back(rng_pkg::rnd_byte_t'(wdata));
                        vec_data.push_back(rng_pkg::rnd_byte_t'(data));
                        vec_resp.push_back(rng_pkg::axil_resp_t'(resp));
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_vector(input int idx);
        rng_pkg::rnd_byte_t  data;
        rng_pkg::axil_resp_t resp;
        if (vec_op[idx] == "write") begin
            axil_write(vec_addr[idx], vec_wdata[idx], resp);
            check_resp(vec_name[idx], vec_resp[idx], resp);
        end else if (vec_op[idx] == "read") begin
            axil_read(vec_addr[idx], data, resp);
            check_byte(vec_name[idx], vec_data[idx], data);
            check_resp(vec_name[idx], vec_resp[idx], resp);
        end else if (vec_op[idx] == "poll") begin
            // Timeout catches a count that never arrives
            do begin
                axil_read(vec_addr[idx], data, resp);
                check_resp(vec_name[idx], vec_resp[idx], resp);
            end while (data !== vec_data[idx]);
        end else begin
            abort_run($sformatf("Vector %s has an unknown operation %s",
                                vec_name[idx], vec_op[idx]));
        end
    endtask

    // Hang guard
    always @(posedge clk) begin
        if (rst_n && cycle_limit > 0) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= cycle_limit) begin
                abort_run($sformatf("Timeout after %0d cycles, the run hung", cycle_count));
            end
        end
    end

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wstrb   = 1'b0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        lfsr_state    = 16'd42;
        cycle_count   = 0;
        cycle_limit   = 0;
        load_vectors();
        cycle_limit = vec_name.size() * 300;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < vec_name.size(); i++) begin
            run_vector(i);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== lfsr_rng_axil.f ====
+incdir+design
design/rng_pkg.sv
design/triple_lfsr_gen.sv
design/rnd_fifo.sv
design/axil_rng_regs.sv
design/lfsr_rng_axil.sv
bench/tb_lfsr_rng_axil.sv

// ==== Bender.yml ====
package:
  name: lfsr_rng_axil

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/rng_pkg.sv
      - design/triple_lfsr_gen.sv
      - design/rnd_fifo.sv
      - design/axil_rng_regs.sv
      - design/lfsr_rng_axil.sv
  - target: simulation
    files:
      - bench/tb_lfsr_rng_axil.sv

// ==== bench/rng_vectors.txt ====
# name op addr wdata exp_data exp_resp, numbers in hex, wdata used by write only
# poll rereads addr until the data equals exp_data, exp_data unused by write
reset_en          read   4 00 00 0
reset_status      read   C 00 00 0
reset_rnd_empty   read   0 00 00 2
fill_enable       write  4 01 00 0
fill_poll         poll   C 00 08 0
fill_disable      write  4 00 00 0
drain_byte_1      read   0 00 CF 0
drain_byte_2      read   0 00 9E 0
drain_byte_3      read   0 00 3D 0
drain_byte_4      read   0 00 7B 0
drain_byte_5      read   0 00 F6 0
drain_byte_6      read   0 00 ED 0
drain_byte_7      read   0 00 DA 0
drain_byte_8      read   0 00 B4 0
drain_status      read   C 00 01 0
bp_enable         write  4 01 00 0
bp_poll           poll   C 00 08 0
bp_disable        write  4 00 00 0
bp_byte_9         read   0 00 6A 0
bp_byte_10        read   0 00 D5 0
bp_byte_11        read   0 00 AB 0
bp_byte_12        read   0 00 58 0
bp_byte_13        read   0 00 B0 0
bp_byte_14        read   0 00 61 0
bp_byte_15        read   0 00 C4 0
bp_byte_16        read   0 00 89 0
bp_status         read   C 00 01 0
reseed_pulse      write  8 01 00 0
reseed_status     read   C 00 00 0
reseed_enable     write  4 01 00 0
reseed_poll       poll   C 00 08 0
reseed_disable    write  4 00 00 0
reseed_byte_1     read   0 00 CF 0
reseed_byte_2     read   0 00 9E 0
err_enable        write  4 01 00 0
err_write_rnd     write  0 55 00 2
err_write_status  write  C 55 00 2
err_read_unmapped read   2 00 00 2
err_write_unmapped write 6 01 00 2
err_en_kept       read   4 00 01 0
err_reseed_reads  read   8 00 00 0
